/* alu_cluster.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_cluster (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          in_valid,
    input  alu_pkg::alu_req_t  in_req,
    output logic               in_credit,
    output logic               out_valid,
    output alu_pkg::alu_res_t  out_res,
    input  wire logic          out_credit
);
    import alu_pkg::*;

    logic [NUM_LANES-1:0]      lane_valid;
    alu_req_t                  lane_req;                // Broadcast request
    logic [NUM_LANES-1:0]      lane_credit;
    logic [NUM_LANES-1:0]      res_valid;
    alu_res_t [NUM_LANES-1:0]  lane_res;
    logic [NUM_LANES-1:0]      res_take;

    alu_dispatch u_dispatch (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_req      (in_req),
        .in_credit   (in_credit),
        .lane_valid  (lane_valid),
        .lane_req    (lane_req),
        .lane_credit (lane_credit)
    );

    // Identical lanes, one op each
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        alu_lane u_lane (
            .clk         (clk),
            .rst         (rst),
            .lane_valid  (lane_valid[g]),
            .lane_req    (lane_req),
            .res_take    (res_take[g]),
            .res_valid   (res_valid[g]),
            .res         (lane_res[g]),
            .lane_credit (lane_credit[g])
        );
    end

    alu_collect u_collect (
        .clk        (clk),
        .rst        (rst),
        .res_valid  (res_valid),
        .res        (lane_res),
        .res_take   (res_take),
        .out_valid  (out_valid),
        .out_res    (out_res),
        .out_credit (out_credit)
    );

endmodule

`default_nettype wire

/* alu_cluster_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_cluster_chk (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          in_valid,
    input  wire logic                          in_credit,
    input  wire logic                          out_valid,
    input  wire logic                          out_credit,
    input  wire logic [alu_pkg::NUM_LANES-1:0] lane_valid
);
    import alu_pkg::*;

    int held;                                           // Downstream credits the cluster holds
    int up_held;                                        // Credits still held upstream
    int fail_cnt = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            held    <= OUT_CREDITS;
            up_held <= IN_DEPTH;
        end else begin
            held    <= held + int'(out_credit) - int'(out_valid);
            up_held <= up_held + int'(in_credit) - int'(in_valid);
        end
    end

    a_out_cred: assert property (@(posedge clk) disable iff (rst) out_valid |-> held > 0)
        else begin
            fail_cnt++;
            $error("out_valid sent with no downstream credit left");
        end

    // Freed slots can never outnumber the queue
    a_in_cred: assert property (@(posedge clk) disable iff (rst) in_credit |-> up_held < IN_DEPTH)
        else begin
            fail_cnt++;
            $error("in_credit returned beyond the queue depth");
        end

    a_reset: assert property (@(posedge clk)
        $fell(rst) |-> !out_valid && !in_credit && (lane_valid == '0))
        else begin
            fail_cnt++;
            $error("Outputs active in the first cycle after reset");
        end

endmodule

bind alu_cluster alu_cluster_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_credit (out_credit),
    .lane_valid (lane_valid)
);

`default_nettype wire

/* alu_cluster_mon.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_cluster_mon (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         in_valid,
    input  alu_pkg::alu_req_t in_req,
    input  wire logic         out_valid,
    input  alu_pkg::alu_res_t out_res,
    output int                accepted,
    output int                checked,
    output int                errors
);
    import alu_pkg::*;

    alu_res_t exp_q[$];                                 // Expected results, issue order
    alu_req_t req_q[$];                                 // Ops behind them, for error lines
    alu_res_t exp_r;
    alu_req_t req_r;

    function automatic alu_res_t ref_result(alu_req_t r);
        alu_res_t           e;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [31:0]        quot;
        logic [31:0]        rem;
        logic               sgn;
        sa  = r.a;
        sb  = r.b;
        sgn = (r.op == OP_DIV) || (r.op == OP_MOD);
        if (r.b == '0) begin
            quot = '1;                                  // Divide by zero
            rem  = r.a;
        end else if (sgn && r.a == 32'h8000_0000 && r.b == '1) begin
            quot = r.a;                                 // Overflow wraps to min
            rem  = '0;
        end else if (sgn) begin
            quot = sa / sb;                             // Truncates toward zero
            rem  = sa % sb;
        end else begin
            quot = r.a / r.b;
            rem  = r.a % r.b;
        end
        case (r.op)
            OP_ADD:           e.value = r.a + r.b;
            OP_SUB:           e.value = r.a - r.b;
            OP_AND:           e.value = r.a & r.b;
            OP_OR:            e.value = r.a | r.b;
            OP_XOR:           e.value = r.a ^ r.b;
            OP_SLL:           e.value = r.a << r.b[4:0];
            OP_SRL:           e.value = r.a >> r.b[4:0];
            OP_SRA:           e.value = sa >>> r.b[4:0];
            OP_DIV, OP_DIVU:  e.value = quot;
            OP_MOD, OP_MODU:  e.value = rem;
            default:          e.value = '0;             // Codes 8 to 11
        endcase
        e.comp = (sa == sb) ? 2'b00 : ((sa < sb) ? 2'b01 : 2'b10);
        return e;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            accepted = 0;
            checked  = 0;
            errors   = 0;
        end else begin
            // Pop before push, latency is never zero
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR at %0t: result %h with no op outstanding", $time, out_res);
                end else begin
                    exp_r = exp_q.pop_front();
                    req_r = req_q.pop_front();
                    checked++;
                    if (out_res !== exp_r) begin
                        errors++;
                        $display("ERROR at %0t: op %0d a %h b %h gave %h/%b, expected %h/%b",
                                 $time, req_r.op, req_r.a, req_r.b, out_res.value,
                                 out_res.comp, exp_r.value, exp_r.comp);
                    end
                end
            end
            if (in_valid) begin
                exp_q.push_back(ref_result(in_req));
                req_q.push_back(in_req);
                accepted++;
            end
        end
    end

endmodule

`default_nettype wire

/* alu_collect.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_collect (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire logic [alu_pkg::NUM_LANES-1:0]          res_valid,
    input  alu_pkg::alu_res_t [alu_pkg::NUM_LANES-1:0]  res,
    output logic [alu_pkg::NUM_LANES-1:0]               res_take,
    output logic                                        out_valid,
    output alu_pkg::alu_res_t                           out_res,
    input  wire logic                                   out_credit
);
    import alu_pkg::*;

    logic [LANE_W-1:0]  ptr;                            // Same order as dispatch
    logic [CRED_W-1:0]  credits;
    logic               take;

    // Lane results hold while no credit is left
    assign take     = res_valid[ptr] && (credits != '0);
    assign res_take = take ? (NUM_LANES'(1) << ptr) : '0;

    always_ff @(posedge clk) begin
        if (take) begin
            out_res <= res[ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr       <= '0;
            out_valid <= 1'b0;
            credits   <= CRED_W'(OUT_CREDITS);          // Downstream buffer size
        end else begin
            out_valid <= take;
            if (take) begin
                ptr <= ptr + 1'b1;
            end
            // Credit spent at take, which is the out_valid of the next cycle
            case ({out_credit, take})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

/* alu_dispatch.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_dispatch (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            in_valid,
    input  alu_pkg::alu_req_t                    in_req,
    output logic                                 in_credit,
    output logic [alu_pkg::NUM_LANES-1:0]        lane_valid,
    output alu_pkg::alu_req_t                    lane_req,
    input  wire logic [alu_pkg::NUM_LANES-1:0]   lane_credit
);
    import alu_pkg::*;

    alu_req_t               queue_mem [IN_DEPTH];       // Payload only
    logic [QUEUE_W-1:0]     wr_ptr;
    logic [QUEUE_W-1:0]     rd_ptr;
    logic [QUEUE_W:0]       count;
    logic [LANE_W-1:0]      rr_ptr;                     // Next lane in issue order
    logic [NUM_LANES-1:0]   lane_cred;                  // One slot per lane
    logic                   issue;
    logic [NUM_LANES-1:0]   issue_mask;

    // Wait on the pointer lane, never skip it
    assign issue      = (count != '0) && lane_cred[rr_ptr];
    assign issue_mask = issue ? (NUM_LANES'(1) << rr_ptr) : '0;

    assign lane_valid = issue_mask;
    assign lane_req   = queue_mem[rd_ptr];              // Shared by all lanes
    assign in_credit  = issue;                          // Slot freed as it leaves

    always_ff @(posedge clk) begin
        if (in_valid) begin
            queue_mem[wr_ptr] <= in_req;                // Upstream credits prevent overflow
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            rr_ptr    <= '0;
            lane_cred <= '1;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (issue) begin
                rd_ptr <= rd_ptr + 1'b1;
                rr_ptr <= rr_ptr + 1'b1;
            end
            case ({in_valid, issue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Returned credit never hits the lane being issued
            lane_cred <= (lane_cred & ~issue_mask) | lane_credit;
        end
    end

endmodule

`default_nettype wire

/* alu_divider.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_divider (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        start,
    input  wire logic        is_signed,
    input  wire logic [31:0] a,
    input  wire logic [31:0] b,
    output logic      [31:0] quot,
    output logic      [31:0] rem,
    output logic             done
);
    import alu_pkg::*;

    // One load cycle, then the steps, then one sign fix cycle
    localparam int STEPS = DIV_CYCLES - 2;
    localparam logic [5:0] STEP_LAST = 6'(STEPS - 1);

    logic        busy;                                  // Shift-subtract phase
    logic        fix;                                   // Sign fix cycle
    logic [5:0]  cnt;
    logic [31:0] q_sh;                                  // Dividend in, quotient out
    logic [31:0] r_acc;                                 // Partial remainder
    logic [31:0] d_mag;                                 // Divisor magnitude
    logic        neg_q;
    logic        neg_r;
    logic [31:0] a_mag;
    logic [31:0] b_mag;
    logic [32:0] r_sh;
    logic [33:0] diff;

    // Magnitudes only when signed
    assign a_mag = (is_signed && a[31]) ? -a : a;
    assign b_mag = (is_signed && b[31]) ? -b : b;

    // Restoring step
    assign r_sh = {r_acc, q_sh[31]};
    assign diff = {1'b0, r_sh} - {2'b00, d_mag};        // diff[33] set means it does not fit

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            fix  <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= fix;                                // Single pulse after fix
            fix  <= busy && (cnt == STEP_LAST);
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 6'd1;
                if (cnt == STEP_LAST) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            q_sh  <= a_mag;
            r_acc <= '0;
            d_mag <= b_mag;
            // Zero divisor keeps the all-ones quotient unnegated
            neg_q <= is_signed && (a[31] ^ b[31]) && (b != '0);
            neg_r <= is_signed && a[31];                // Remainder follows dividend
        end else if (busy) begin
            q_sh  <= {q_sh[30:0], ~diff[33]};
            r_acc <= diff[33] ? r_sh[31:0] : diff[31:0];
        end
        if (fix) begin
            // Min / -1 wraps back to min on its own
            quot <= neg_q ? -q_sh : q_sh;
            rem  <= neg_r ? -r_acc : r_acc;
        end
    end

endmodule

`default_nettype wire

/* alu_lane.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_lane (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             lane_valid,
    input  alu_pkg::alu_req_t     lane_req,
    input  wire logic             res_take,
    output logic                  res_valid,
    output alu_pkg::alu_res_t     res,
    output logic                  lane_credit
);
    import alu_pkg::*;

    alu_req_t    req_q;                                 // Held op and operands
    logic [31:0] value_d;
    logic [31:0] value_q;                               // One-cycle result
    logic        ready_q;
    logic        is_div;
    logic        is_div_q;
    logic [31:0] div_quot;
    logic [31:0] div_rem;
    logic        div_done;

    assign is_div   = (lane_req.op[3:2] == 2'b11);      // Codes 12 to 15
    assign is_div_q = (req_q.op[3:2] == 2'b11);

    alu_divider u_div (
        .clk       (clk),
        .rst       (rst),
        .start     (lane_valid && is_div),
        .is_signed (~lane_req.op[1]),                   // DIV and MOD
        .a         (lane_req.a),
        .b         (lane_req.b),
        .quot      (div_quot),
        .rem       (div_rem),
        .done      (div_done)
    );

    always_comb begin
        case (lane_req.op)
            OP_ADD:  value_d = lane_req.a + lane_req.b;
            OP_SUB:  value_d = lane_req.a - lane_req.b;
            OP_AND:  value_d = lane_req.a & lane_req.b;
            OP_OR:   value_d = lane_req.a | lane_req.b;
            OP_XOR:  value_d = lane_req.a ^ lane_req.b;
            OP_SLL:  value_d = lane_req.a << lane_req.b[4:0];
            OP_SRL:  value_d = lane_req.a >> lane_req.b[4:0];
            OP_SRA:  value_d = $signed(lane_req.a) >>> lane_req.b[4:0];
            default: value_d = '0;                      // Old multiply codes and divides
        endcase
    end

    always_ff @(posedge clk) begin
        if (lane_valid) begin
            req_q   <= lane_req;
            value_q <= value_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q     <= 1'b0;
            lane_credit <= 1'b0;
        end else begin
            lane_credit <= res_take;                    // Slot free one cycle later
            if (res_take) begin
                ready_q <= 1'b0;
            end else if ((lane_valid && !is_div) || div_done) begin
                ready_q <= 1'b1;
            end
        end
    end

    // Divider outputs stay put until the next start
    assign res_valid = ready_q || div_done;

    always_comb begin
        res.value = is_div_q ? (req_q.op[0] ? div_rem : div_quot) : value_q;
        if (req_q.a == req_q.b) begin
            res.comp = 2'b00;
        end else if ($signed(req_q.a) < $signed(req_q.b)) begin
            res.comp = 2'b01;
        end else begin
            res.comp = 2'b10;
        end
    end

endmodule

`default_nettype wire

/* alu_pkg.sv */
`default_nettype none

package alu_pkg;

    // Cluster sizing
    localparam int NUM_LANES   = 4;
    localparam int LANE_W      = 2;                     // Lane index width
    localparam int IN_DEPTH    = 4;                     // Dispatch queue slots
    localparam int OUT_CREDITS = 2;                     // Downstream credits after reset
    localparam int DIV_CYCLES  = 34;                    // Start to done, fixed

    // Derived widths
    localparam int QUEUE_W = $clog2(IN_DEPTH);          // Queue pointer
    localparam int CRED_W  = $clog2(OUT_CREDITS + 1);   // Output credit counter

    // Op codes, same encoding as the original ALU ctrl field
    // 8 to 11 were multiply slots and stay undefined
    typedef enum logic [3:0] {
        OP_ADD  = 4'b0000,
        OP_SUB  = 4'b0001,
        OP_AND  = 4'b0010,
        OP_OR   = 4'b0011,
        OP_XOR  = 4'b0100,
        OP_SLL  = 4'b0101,
        OP_SRL  = 4'b0110,
        OP_SRA  = 4'b0111,
        OP_DIV  = 4'b1100,                              // Signed quotient
        OP_MOD  = 4'b1101,                              // Signed remainder
        OP_DIVU = 4'b1110,
        OP_MODU = 4'b1111
    } alu_op_e;

    // One operation as it travels from input to lane
    typedef struct packed {
        alu_op_e     op;
        logic [31:0] a;
        logic [31:0] b;                                 // Shifts use b[4:0] only
    } alu_req_t;

    // Lane result
    // comp is 00 for a == b, 01 for a < b signed, 10 for a > b
    typedef struct packed {
        logic [31:0] value;
        logic [1:0]  comp;
    } alu_res_t;

endpackage

`default_nettype wire

/* filelist.f */
alu_pkg.sv
alu_divider.sv
alu_lane.sv
alu_dispatch.sv
alu_collect.sv
alu_cluster.sv
alu_cluster_chk.sv
alu_cluster_mon.sv
tb_alu_cluster.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator, success only when the pass line appears
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_alu_cluster \
    -o sim_tb \
    && ./obj_dir/sim_tb +verilator+error+limit+1000 | tee /dev/stderr | grep -q '^No errors$' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tb_alu_cluster.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_alu_cluster;
    import alu_pkg::*;

    localparam int N_RAND      = 160;
    localparam int N_BP        = 60;                    // Ops for the back-pressure rounds
    localparam int HOLD        = 300;                   // Cycles with credits withheld
    localparam int N_HOLDS     = 3;
    localparam int N_OPS_MAX   = 32 + N_RAND + N_BP;
    localparam int WDOG_CYCLES = N_OPS_MAX * (DIV_CYCLES + 10) + N_HOLDS * (HOLD + 80) + 500;

    logic        clk        = 1'b0;
    logic        rst        = 1'b1;
    logic        in_valid   = 1'b0;
    alu_req_t    in_req     = '0;
    logic        out_credit = 1'b0;
    logic        in_credit;
    logic        out_valid;
    alu_res_t    out_res;

    alu_req_t    pending[$];                            // Ops waiting for an upstream credit
    alu_req_t    next_req;
    int          pushed = 0;
    int          up_cred;
    int          owed;                                  // Results not credited back yet
    logic        give;
    logic        hold_credits = 1'b0;
    logic        burst = 1'b0;
    logic [31:0] stim_lfsr = 32'h4bfe;
    logic [31:0] cred_lfsr = 32'h4bfe;
    int          accepted;
    int          checked;
    int          mon_errors;
    int          tb_errors = 0;
    int          acc_mid;
    int          total;

    always #4 clk = ~clk;

    alu_cluster u_alu_cluster (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_res    (out_res),
        .out_credit (out_credit)
    );

    alu_cluster_mon u_mon (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_res   (out_res),
        .accepted  (accepted),
        .checked   (checked),
        .errors    (mon_errors)
    );

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], stim_lfsr[0]};
            stim_lfsr = lfsr_step(stim_lfsr);
        end
    endtask

    task automatic push_op(input logic [3:0] code, input logic [31:0] a, input logic [31:0] b);
        alu_req_t r;
        r.op = alu_op_e'(code);
        r.a  = a;
        r.b  = b;
        pending.push_back(r);
        pushed++;
    endtask

    task automatic push_random(input int n);
        logic [31:0] code;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] mode;
        for (int i = 0; i < n; i++) begin
            draw(4, code);
            draw(32, a);
            draw(32, b);
            draw(2, mode);
            if (mode == 0) begin
                b = a;                                  // Equal operands
            end else if (mode == 1) begin
                b = {{27{b[4]}}, b[4:0]};               // Small divisor of either sign
            end
            push_op(code[3:0], a, b);
        end
    endtask

    task automatic wait_drain;
        while (checked < pushed) @(negedge clk);
        repeat (10) @(negedge clk);                     // Room for a stray extra result
    endtask

    task automatic hold_round;
        repeat (40) @(negedge clk);
        hold_credits = 1'b1;
        repeat (HOLD - 100) @(negedge clk);
        acc_mid = accepted;
        repeat (100) @(negedge clk);
        if (accepted != acc_mid) begin
            tb_errors++;
            $display("Input kept flowing at %0t while the cluster was stalled", $time);
        end
        // Full stall means queue and every lane hold an op
        if (pending.size() != 0 && accepted - checked != IN_DEPTH + NUM_LANES) begin
            tb_errors++;
            $display("ERROR at %0t: stall holds %0d ops, expected %0d", $time,
                     accepted - checked, IN_DEPTH + NUM_LANES);
        end
        hold_credits = 1'b0;
        burst = 1'b1;                                   // Give everything back at once
        repeat (20) @(negedge clk);
        burst = 1'b0;
    endtask

    // Upstream side, spends counted credits
    always @(posedge clk) begin
        if (rst) begin
            in_valid <= 1'b0;
            up_cred = IN_DEPTH;
        end else begin
            if (in_credit) begin
                up_cred++;
            end
            if (pending.size() != 0 && up_cred > 0) begin
                next_req = pending.pop_front();
                in_req   <= next_req;
                in_valid <= 1'b1;
                up_cred--;
            end else begin
                in_valid <= 1'b0;
            end
        end
    end

    // Downstream side, one credit back per consumed result
    always @(posedge clk) begin
        if (rst) begin
            out_credit <= 1'b0;
            owed = 0;
        end else begin
            give = 1'b0;
            if (owed > 0 && !hold_credits) begin
                if (burst) begin
                    give = 1'b1;
                end else begin
                    give = cred_lfsr[0];
                    cred_lfsr = lfsr_step(cred_lfsr);
                end
            end
            out_credit <= give;
            owed = owed + int'(out_valid) - int'(give);
        end
    end

    initial begin
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        push_op(OP_ADD, 32'd5, 32'd5);                  // Compare equal
        push_op(OP_SUB, 32'hFFFF_FFFD, 32'd7);          // Less, signed
        push_op(OP_AND, 32'd7, 32'hFFFF_FFFD);          // Greater
        push_op(OP_OR, 32'h8000_0000, 32'h7FFF_FFFF);
        push_op(OP_XOR, 32'hA5A5_A5A5, 32'h5A5A_0FF0);
        push_op(OP_SLL, 32'h0000_0001, 32'hFFFF_FFE3);  // High bits of b ignored
        push_op(OP_SRL, 32'h8000_0000, 32'h0000_0121);
        push_op(OP_SRA, 32'h8000_0000, 32'h7FFF_FFFF);
        push_op(OP_DIV, 32'hFFFF_FFF9, 32'd0);          // Divide by zero
        push_op(OP_MOD, 32'hFFFF_FFF9, 32'd0);
        push_op(OP_DIVU, 32'd9, 32'd0);
        push_op(OP_MODU, 32'd9, 32'd0);
        push_op(OP_DIV, 32'h8000_0000, 32'hFFFF_FFFF);  // Min over minus one
        push_op(OP_MOD, 32'h8000_0000, 32'hFFFF_FFFF);
        push_op(OP_DIV, 32'hFFFF_FFF9, 32'd2);
        push_op(OP_MOD, 32'hFFFF_FFF9, 32'd2);
        push_op(OP_DIV, 32'd7, 32'hFFFF_FFFE);
        push_op(OP_MOD, 32'd7, 32'hFFFF_FFFE);
        push_op(OP_DIVU, 32'hFFFF_FFF9, 32'd2);
        push_op(OP_MODU, 32'hFFFF_FFF9, 32'd2);
        for (int c = 8; c < 12; c++) begin
            push_op(4'(c), 32'd3, 32'd9);               // Old multiply slots
        end
        wait_drain();
        push_random(N_RAND);
        wait_drain();
        push_random(N_BP);
        repeat (N_HOLDS) hold_round();
        wait_drain();
        total = mon_errors + tb_errors + u_alu_cluster.u_chk.fail_cnt;
        $display("Checked %0d of %0d results: %0d compare, %0d flow, %0d assertion errors",
                 checked, pushed, mon_errors, tb_errors, u_alu_cluster.u_chk.fail_cnt);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, run hung with %0d of %0d results back",
                 WDOG_CYCLES, checked, pushed);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
